// ==== src/runner_pkg.sv ====
package runner_pkg;

  // kind of one render slot
  // five kinds, so three bits are needed
  typedef enum logic [2:0] {
    sprite_none,
    sprite_player,
    sprite_player_duck,
    sprite_cactus,
    sprite_bird
  } sprite_t;

  // screen coordinates, one 24-bit word
  typedef struct packed {
    logic [11:0] x;
    logic [11:0] y;
  } pos_t;

  // one sensor sample as two views of the same word
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic signed [15:0] acceleration;
      logic signed [15:0] direction;
    } fields;
  } sensor_word_u;

  // apb byte offsets
  localparam logic [11:0] addr_sample  = 12'h000;
  localparam logic [11:0] addr_control = 12'h004;
  localparam logic [11:0] addr_status  = 12'h008;
  localparam logic [11:0] addr_render  = 12'h00C;

  // control word bits
  localparam int ctrl_step       = 0;
  localparam int ctrl_restart    = 1;
  localparam int ctrl_spawn_en   = 2;
  localparam int ctrl_spawn_kind = 3;

  // game geometry
  localparam logic [11:0] player_x = 12'd40;
  localparam logic [11:0] player_w = 12'd16;
  localparam logic [11:0] screen_w = 12'd640;
  localparam logic [11:0] cactus_h = 12'd24;

  // player height per jump step, ground again after the last one
  localparam int jump_len = 8;
  localparam logic [11:0] jump_arc [jump_len] = '{
    12'd8, 12'd16, 12'd24, 12'd32, 12'd32, 12'd24, 12'd16, 12'd8
  };

endpackage

// ==== src/game_if.sv ====
`timescale 1ns/1ps

interface game_if;
  import runner_pkg::*;

  // latest sample, valid for one cycle after each write
  logic         sample_valid;
  sensor_word_u sample;

  // motion flags
  logic jumping;
  logic ducking;

  // single-cycle command pulses
  logic step;
  logic restart;
  logic spawn_valid;
  logic spawn_bird;

  // engine state back to the status register
  logic [15:0] score;
  logic        game_over;
  logic [11:0] player_y;

  modport regs (
    output sample_valid, sample, step, restart, spawn_valid, spawn_bird,
    input  jumping, ducking, score, game_over, player_y
  );

  modport detect (
    input  sample_valid, sample,
    output jumping, ducking
  );

  modport engine (
    input  step, restart, spawn_valid, spawn_bird, jumping, ducking,
    output score, game_over, player_y
  );

endinterface

// ==== src/render_if.sv ====
`timescale 1ns/1ps

interface render_if #(
  parameter int RENDER_SLOTS = 4
);
  import runner_pkg::*;

  // held frame, one record per slot
  sprite_t sprite [RENDER_SLOTS];
  pos_t    pos    [RENDER_SLOTS];

  // high while the scanner streams the held frame
  logic frame_busy;

  modport engine (
    output sprite, pos,
    input  frame_busy
  );

  modport scan (
    input  sprite, pos,
    output frame_busy
  );

endinterface

// ==== src/sensor_apb_regs.sv ====
`timescale 1ns/1ps

module sensor_apb_regs (
  input  logic        clk_33m,
  input  logic        arst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  game_if.regs        game,
  input  logic        frame_busy,
  output logic        render_start
);
  import runner_pkg::*;

  sensor_word_u sample_q;
  logic         access;
  logic         wr_en;
  logic         addr_known;
  logic         render_blocked;
  logic         render_req;
  logic [31:0]  status_word;

  // no wait states
  assign pready = 1'b1;

  assign access = psel && penable;
  assign wr_en  = access && pwrite;

  assign addr_known = (paddr == addr_sample) || (paddr == addr_control) ||
                      (paddr == addr_status) || (paddr == addr_render);

  // a frame is already pending or streaming
  assign render_blocked = frame_busy || render_start;
  assign render_req     = wr_en && (paddr == addr_render) && !render_blocked;

  assign pslverr = access && (!addr_known ||
                              (pwrite && (paddr == addr_status)) ||
                              (pwrite && (paddr == addr_render) && render_blocked));

  // score, flags, then player height in the low bits
  assign status_word = {game.score, game.game_over, game.jumping, game.ducking,
                        1'b0, game.player_y};

  // read mux, control reads back as zero since it only holds pulses
  always_comb begin
    case (paddr)
      addr_sample: prdata = sample_q.raw;
      addr_status: prdata = status_word;
      addr_render: prdata = {31'b0, frame_busy};
      default:     prdata = 32'b0;
    endcase
  end

  // sample word storage
  always_ff @(posedge clk_33m) begin
    if (wr_en && (paddr == addr_sample)) begin
      sample_q.raw <= pwdata;
    end
  end

  assign game.sample = sample_q;

  // command pulses, one cycle after the access cycle
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      game.sample_valid <= 1'b0;
      game.step         <= 1'b0;
      game.restart      <= 1'b0;
      game.spawn_valid  <= 1'b0;
      game.spawn_bird   <= 1'b0;
      render_start      <= 1'b0;
    end else begin
      game.sample_valid <= wr_en && (paddr == addr_sample);
      game.step         <= wr_en && (paddr == addr_control) && pwdata[ctrl_step];
      game.restart      <= wr_en && (paddr == addr_control) && pwdata[ctrl_restart];
      game.spawn_valid  <= wr_en && (paddr == addr_control) && pwdata[ctrl_spawn_en];
      // kind only matters together with the spawn pulse
      game.spawn_bird   <= wr_en && (paddr == addr_control) && pwdata[ctrl_spawn_en] &&
                           pwdata[ctrl_spawn_kind];
      render_start      <= render_req;
    end
  end

  // access phase always follows a setup phase
  assert property (@(posedge clk_33m) disable iff (!arst_n)
    (psel && penable) |-> $past(psel));

endmodule

// ==== src/motion_detector.sv ====
`timescale 1ns/1ps

module motion_detector #(
  parameter logic signed [15:0] JUMP_THRESHOLD = 16'sd1000,
  parameter logic signed [15:0] DUCK_THRESHOLD = 16'sd1000
) (
  input logic    clk_33m,
  input logic    arst_n,
  game_if.detect game
);

  logic jump_hit;
  logic duck_hit;

  // signed compares on the field view of the sample
  assign jump_hit = game.sample.fields.acceleration > JUMP_THRESHOLD;
  assign duck_hit = game.sample.fields.direction < -DUCK_THRESHOLD;

  // flags hold until the next sample arrives
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      game.jumping <= 1'b0;
      game.ducking <= 1'b0;
    end else if (game.sample_valid) begin
      game.jumping <= jump_hit;
      // jumping wins over ducking
      game.ducking <= duck_hit && !jump_hit;
    end
  end

  assert property (@(posedge clk_33m) disable iff (!arst_n)
    game.jumping |-> !game.ducking);

endmodule

// ==== src/runner.sv ====
`timescale 1ns/1ps

module runner #(
  parameter int MAX_OBSTACLES = 3,
  parameter int RENDER_SLOTS  = 4,
  parameter int SPEED         = 16
) (
  input logic      clk_33m,
  input logic      arst_n,
  game_if.engine   game,
  render_if.engine render
);
  import runner_pkg::*;

  localparam logic [11:0] speed_px = 12'(SPEED);
  localparam logic [11:0] hit_lo   = player_x;
  localparam logic [11:0] hit_hi   = player_x + player_w - 12'd1;

  // obstacle slots
  logic        obs_valid [MAX_OBSTACLES];
  logic        obs_bird  [MAX_OBSTACLES];
  logic [11:0] obs_x     [MAX_OBSTACLES];
  logic        nxt_valid [MAX_OBSTACLES];
  logic        nxt_bird  [MAX_OBSTACLES];
  logic [11:0] nxt_x     [MAX_OBSTACLES];

  // jump position, 0 on the ground, 1 to jump_len in the air
  logic [3:0]  jump_pos;
  logic [3:0]  nxt_jump_pos;
  logic [11:0] player_y;
  logic [11:0] nxt_y;
  logic [15:0] score;
  logic [15:0] nxt_score;
  logic        game_over;
  logic        nxt_over;
  logic        step_go;

  // steps are frozen after a crash and while a frame streams
  assign step_go = game.step && !render.frame_busy && !game_over;

  assign player_y = (jump_pos == 4'd0) ? 12'd0 : jump_arc[3'(jump_pos - 4'd1)];
  assign nxt_y    = (nxt_jump_pos == 4'd0) ? 12'd0 : jump_arc[3'(nxt_jump_pos - 4'd1)];

  always_comb begin
    logic hit;
    logic placed;
    hit          = 1'b0;
    placed       = 1'b0;
    nxt_valid    = obs_valid;
    nxt_bird     = obs_bird;
    nxt_x        = obs_x;
    nxt_jump_pos = jump_pos;
    nxt_score    = score;
    nxt_over     = game_over;
    if (step_go) begin
      // advance the jump arc
      if (jump_pos == 4'd0) begin
        if (game.jumping) begin
          nxt_jump_pos = 4'd1;
        end
      end else if (jump_pos == 4'(jump_len)) begin
        nxt_jump_pos = 4'd0;
      end else begin
        nxt_jump_pos = jump_pos + 4'd1;
      end
      // scroll left, drop what leaves the screen
      for (int i = 0; i < MAX_OBSTACLES; i++) begin
        if (obs_valid[i]) begin
          if (obs_x[i] < speed_px) begin
            nxt_valid[i] = 1'b0;
          end else begin
            nxt_x[i] = obs_x[i] - speed_px;
          end
        end
        // collision against the moved obstacle and the new height
        if (nxt_valid[i] && (nxt_x[i] >= hit_lo) && (nxt_x[i] <= hit_hi)) begin
          if (obs_bird[i] ? !game.ducking : (nxt_y < cactus_h)) begin
            hit = 1'b1;
          end
        end
      end
      if (hit) begin
        nxt_over = 1'b1;
      end else begin
        nxt_score = score + 16'd1;
      end
    end
    // new obstacle into the lowest free slot, dropped when full
    if (game.spawn_valid) begin
      for (int i = 0; i < MAX_OBSTACLES; i++) begin
        if (!placed && !nxt_valid[i]) begin
          nxt_valid[i] = 1'b1;
          nxt_bird[i]  = game.spawn_bird;
          nxt_x[i]     = screen_w - 12'd1;
          placed       = 1'b1;
        end
      end
    end
  end

  // control state
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      obs_valid <= '{default: 1'b0};
      jump_pos  <= 4'd0;
      score     <= 16'd0;
      game_over <= 1'b0;
    end else if (game.restart) begin
      obs_valid <= '{default: 1'b0};
      jump_pos  <= 4'd0;
      score     <= 16'd0;
      game_over <= 1'b0;
    end else begin
      obs_valid <= nxt_valid;
      jump_pos  <= nxt_jump_pos;
      score     <= nxt_score;
      game_over <= nxt_over;
    end
  end

  // obstacle payload, only meaningful with its valid bit
  always_ff @(posedge clk_33m) begin
    obs_x    <= nxt_x;
    obs_bird <= nxt_bird;
  end

  // frame snapshot, frozen while the scanner walks it
  always_ff @(posedge clk_33m) begin
    if (!render.frame_busy) begin
      render.sprite[0] <= (game.ducking && (player_y == 12'd0)) ? sprite_player_duck
                                                                : sprite_player;
      render.pos[0]    <= '{x: player_x, y: player_y};
      for (int s = 1; s < RENDER_SLOTS; s++) begin
        if (obs_valid[s-1]) begin
          render.sprite[s] <= obs_bird[s-1] ? sprite_bird : sprite_cactus;
          render.pos[s]    <= '{x: obs_x[s-1], y: 12'd0};
        end else begin
          render.sprite[s] <= sprite_none;
          render.pos[s]    <= '0;
        end
      end
    end
  end

  assign game.score     = score;
  assign game.game_over = game_over;
  assign game.player_y  = player_y;

  // score frozen after a crash until restart
  assert property (@(posedge clk_33m) disable iff (!arst_n)
    (game_over && !game.restart) |=> $stable(score));

endmodule

// ==== src/render_scanner.sv ====
`timescale 1ns/1ps

module render_scanner #(
  parameter int RENDER_SLOTS = 4,
  localparam int SLOT_W = $clog2(RENDER_SLOTS)
) (
  input  logic                clk_33m,
  input  logic                arst_n,
  render_if.scan              render,
  input  logic                render_start,
  input  logic                render_ready,
  output logic                render_valid,
  output runner_pkg::sprite_t render_sprite,
  output runner_pkg::pos_t    render_pos,
  output logic [SLOT_W-1:0]   render_slot
);

  logic              busy;
  logic [SLOT_W-1:0] slot;
  logic              last_slot;

  assign last_slot = (slot == SLOT_W'(RENDER_SLOTS - 1));

  // walk the held frame, one slot per handshake
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      slot <= '0;
    end else if (!busy) begin
      if (render_start) begin
        busy <= 1'b1;
        slot <= '0;
      end
    end else if (render_ready) begin
      if (last_slot) begin
        busy <= 1'b0;
        slot <= '0;
      end else begin
        slot <= slot + 1'b1;
      end
    end
  end

  // valid for the whole frame, record picked straight from the held slots
  assign render.frame_busy = busy;
  assign render_valid      = busy;
  assign render_slot       = slot;
  assign render_sprite     = render.sprite[slot];
  assign render_pos        = render.pos[slot];

  // stalled record must hold until taken
  assert property (@(posedge clk_33m) disable iff (!arst_n)
    (render_valid && !render_ready) |=>
      (render_valid && $stable(render_slot) && $stable(render_sprite) &&
       $stable(render_pos)));

endmodule

// ==== src/runner_top.sv ====
`timescale 1ns/1ps

module runner_top #(
  parameter int MAX_OBSTACLES = 3,
  parameter int SPEED = 16,
  parameter logic signed [15:0] JUMP_THRESHOLD = 16'sd1000,
  parameter logic signed [15:0] DUCK_THRESHOLD = 16'sd1000,
  localparam int RENDER_SLOTS = MAX_OBSTACLES + 1,
  localparam int SLOT_W = $clog2(RENDER_SLOTS)
) (
  input  logic                clk_33m,
  input  logic                arst_n,
  // host apb port
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [11:0]         paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  // sprite record stream
  input  logic                render_ready,
  output logic                render_valid,
  output runner_pkg::sprite_t render_sprite,
  output runner_pkg::pos_t    render_pos,
  output logic [SLOT_W-1:0]   render_slot
);

  logic render_start;

  game_if game ();
  render_if #(.RENDER_SLOTS(RENDER_SLOTS)) render ();

  sensor_apb_regs regs_inst (
    .clk_33m, .arst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .game         (game.regs),
    .frame_busy   (render.frame_busy),
    .render_start (render_start)
  );

  motion_detector #(
    .JUMP_THRESHOLD (JUMP_THRESHOLD),
    .DUCK_THRESHOLD (DUCK_THRESHOLD)
  ) motion_detector_inst (
    .clk_33m, .arst_n,
    .game (game.detect)
  );

  runner #(
    .MAX_OBSTACLES (MAX_OBSTACLES),
    .RENDER_SLOTS  (RENDER_SLOTS),
    .SPEED         (SPEED)
  ) runner_inst (
    .clk_33m, .arst_n,
    .game   (game.engine),
    .render (render.engine)
  );

  render_scanner #(.RENDER_SLOTS(RENDER_SLOTS)) render_scanner_inst (
    .clk_33m, .arst_n,
    .render       (render.scan),
    .render_start (render_start),
    .render_ready, .render_valid, .render_sprite, .render_pos, .render_slot
  );

endmodule

// ==== tests/tb_runner.sv ====
`timescale 1ns/1ps

module tb_runner;
  import runner_pkg::*;

  // default top parameters, so four render slots
  localparam int SLOTS = 4;
  localparam int SLOT_W = 2;
  localparam string DATA_FILE = "tests/runner_testdata.txt";

  logic              clk_33m = 1'b0;
  logic              arst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [11:0]       paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              render_ready = 1'b0;
  logic              render_valid;
  sprite_t           render_sprite;
  pos_t              render_pos;
  logic [SLOT_W-1:0] render_slot;

  int          seed = 32'ha42e_f82e;
  logic [31:0] rnd;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          ops_total = 0;
  // expected records of the next frame
  sprite_t     exp_sprite [SLOTS];
  pos_t        exp_pos    [SLOTS];

  runner_top UUT (.*);

  // 8 ns period
  always #4 clk_33m = ~clk_33m;

  // sink stalls, new draw every falling edge
  always @(negedge clk_33m) begin
    rnd = $random(seed);
    render_ready = rnd[0];
  end

  always @(posedge clk_33m) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the run went past %0d cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_status(input logic [31:0] got, input logic got_err,
                              input logic [31:0] exp, input logic exp_err);
    if (got !== exp) begin
      $display("FAILED prdata got %h expected %h", got, exp);
      abort_run();
    end
    if (got_err !== exp_err) begin
      $display("FAILED pslverr got %h expected %h", got_err, exp_err);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_slot(input logic [SLOT_W-1:0] got, input logic [SLOT_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED render_slot got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_sprite(input int slot, input sprite_t got, input sprite_t exp);
    if (got !== exp) begin
      $display("FAILED render_sprite slot %0d got %h expected %h", slot, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pos(input int slot, input pos_t got, input pos_t exp);
    if (got !== exp) begin
      $display("FAILED render_pos slot %0d got %h expected %h", slot, got, exp);
      abort_run();
    end
  endtask

  task automatic reject_line(input string line);
    $display("malformed testdata line: %s", line);
    abort_run();
  endtask

  // setup, access, then idle, all on falling edges
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic err);
    @(negedge clk_33m);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk_33m);
    penable = 1'b1;
    #1;
    check_flag("pready", pready, 1'b1);
    err = pslverr;
    @(negedge clk_33m);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk_33m);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk_33m);
    penable = 1'b1;
    #1;
    check_flag("pready", pready, 1'b1);
    data = prdata;
    err = pslverr;
    @(negedge clk_33m);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // one frame request, a second request while it streams, then the records
  task automatic run_frame();
    logic err;
    logic err_busy;
    int   n_got;
    apb_write(addr_render, 32'h0, err);
    check_flag("pslverr", err, 1'b0);
    n_got = 0;
    fork
      begin
        apb_write(addr_render, 32'h0, err_busy);
        check_flag("pslverr", err_busy, 1'b1);
      end
      begin
        while (n_got < SLOTS) begin
          // handshake happens at the next rising edge
          @(negedge clk_33m);
          #1;
          if (render_valid && render_ready) begin
            check_slot(render_slot, SLOT_W'(n_got));
            check_sprite(n_got, render_sprite, exp_sprite[n_got]);
            check_pos(n_got, render_pos, exp_pos[n_got]);
            n_got++;
          end
        end
      end
    join
    // dropped second request, so the stream ends here
    @(negedge clk_33m);
    #1;
    check_flag("render_valid", render_valid, 1'b0);
  endtask

  // one share of the cycle budget per testdata line
  task automatic count_ops();
    int    fd;
    int    n;
    string line;
    string op;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", DATA_FILE);
      abort_run();
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s", op);
      if (n >= 1 && op != "#") begin
        ops_total++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_testdata();
    int          fd;
    int          n;
    int          count;
    string       line;
    string       op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] got;
    logic        exp_err;
    logic        err;
    logic [31:0] v [2*SLOTS];
    fd = $fopen(DATA_FILE, "r");
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s", op);
      if (n < 1 || op == "#") begin
        continue;
      end
      if (op == "W") begin
        n = $sscanf(line, "%s %h %h %h %d", op, addr, data, exp_err, count);
        if (n != 5) begin
          reject_line(line);
        end
        repeat (count) begin
          apb_write(addr, data, err);
          check_flag("pslverr", err, exp_err);
        end
      end else if (op == "R") begin
        n = $sscanf(line, "%s %h %h %h", op, addr, data, exp_err);
        if (n != 4) begin
          reject_line(line);
        end
        apb_read(addr, got, err);
        check_status(got, err, data, exp_err);
      end else if (op == "F") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        if (n != 2 * SLOTS + 1) begin
          reject_line(line);
        end
        // sprite and {x, y} pairs, slot 0 first
        for (int i = 0; i < SLOTS; i++) begin
          exp_sprite[i] = sprite_t'(v[2*i][2:0]);
          exp_pos[i] = v[2*i+1][23:0];
        end
        run_frame();
      end else begin
        $display("unknown operation in testdata line: %s", line);
        abort_run();
      end
    end
    $fclose(fd);
  endtask

  initial begin
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    count_ops();
    cycle_limit = 40 * ops_total + 100;
    repeat (5) @(negedge clk_33m);
    arst_n = 1'b1;
    run_testdata();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== tests/runner_testdata.txt ====
# W addr data pslverr count : apb write, repeated count times
# R addr prdata pslverr : apb read with expected values
# F sprite pos (x 12 bits then y 12 bits) for slots 0 to 3 : render frame
# status is score[31:16] game_over[15] jumping[14] ducking[13] player_y[11:0]
R 008 00000000 0
W 000 07D00000 0 1
R 008 00004000 0
R 000 07D00000 0
W 000 03E80000 0 1
W 000 0000F830 0 1
R 008 00002000 0
W 000 07D0F830 0 1
R 008 00004000 0
# jump arc, one read per step
W 004 00000001 0 1
R 008 00014008 0
W 000 00000000 0 1
R 008 00010008 0
W 004 00000001 0 1
R 008 00020010 0
W 004 00000001 0 1
R 008 00030018 0
W 004 00000001 0 1
R 008 00040020 0
W 004 00000001 0 1
R 008 00050020 0
W 004 00000001 0 1
R 008 00060018 0
W 004 00000001 0 1
R 008 00070010 0
W 004 00000001 0 1
R 008 00080008 0
W 004 00000001 0 1
R 008 00090000 0
# cactus cleared by a jump at height 24
W 004 00000002 0 1
W 004 00000004 0 1
F 1 028000 3 27F000 0 000000 0 000000
W 004 00000001 0 34
R 008 00220000 0
F 1 028000 3 05F000 0 000000 0 000000
W 000 07D00000 0 1
W 004 00000001 0 1
R 008 00234008 0
W 000 00000000 0 1
W 004 00000001 0 2
R 008 00250018 0
W 004 00000001 0 6
R 008 002B0000 0
F 1 028000 0 000000 0 000000 0 000000
# cactus hits the player on the ground, score then frozen
W 004 00000004 0 1
W 004 00000001 0 37
R 008 004F8000 0
F 1 028000 3 02F000 0 000000 0 000000
W 004 00000001 0 3
R 008 004F8000 0
W 004 00000002 0 1
R 008 00000000 0
# bird passes while ducking
W 000 0000F830 0 1
W 004 0000000C 0 1
F 2 028000 4 27F000 0 000000 0 000000
W 004 00000001 0 40
R 008 00282000 0
# all slots full, the last spawn is dropped
W 000 00000000 0 1
W 004 00000004 0 1
W 004 00000001 0 1
W 004 0000000C 0 1
W 004 00000001 0 1
W 004 00000004 0 1
W 004 0000000C 0 1
R 008 002A0000 0
F 1 028000 3 25F000 4 26F000 3 27F000
# bird hits a standing player
W 004 00000002 0 1
W 004 0000000C 0 1
W 004 00000001 0 37
R 008 00248000 0
# bus errors
R 010 00000000 1
W 008 00000000 1 1
W 020 00000000 1 1
R 00C 00000000 0

// ==== all.f ====
src/runner_pkg.sv
src/game_if.sv
src/render_if.sv
src/sensor_apb_regs.sv
src/motion_detector.sv
src/runner.sv
src/render_scanner.sv
src/runner_top.sv
tests/tb_runner.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_runner \
  -f all.f --Mdir obj_dir -o tb_runner
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_runner > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
